// ==== logic/ddr5_burst_pkg.sv ====
`default_nettype none

package ddr5_burst_pkg;

	localparam int burst_len = 16;

	typedef logic [15:0] data_t;
	typedef logic [3:0] tag_t;

	// {bank group, bank, row, column}
	typedef logic [29:0] addr_t;

	// {bank group, bank, row, column[9:4]}
	typedef logic [25:0] burst_key_t;

	typedef logic [3:0] beat_t;       // column[3:0]
	typedef logic [burst_len-1:0] beat_mask_t;
	typedef logic [13:0] ca_t;

	typedef enum logic [2:0] {
		cmd_none,
		cmd_activate,
		cmd_read,
		cmd_write,
		cmd_precharge,
		cmd_refresh_all
	} mem_cmd_e;

	typedef enum logic [2:0] {
		slot_empty,
		slot_filling,
		slot_full,
		slot_issued,
		slot_returning
	} slot_state_e;

	// phase 1 opcodes, low bits of CA
	localparam logic [4:0] op_read = 5'b11101;
	localparam logic [4:0] op_write = 5'b01101;
	localparam logic [5:0] op_precharge = 6'b011011;
	localparam logic [4:0] op_refresh_all = 5'b10011;

endpackage

`default_nettype wire

// ==== logic/burst_collector.sv ====
`timescale 1ns/100ps
`default_nettype none

module burst_collector #(
	parameter int num_slots = 4
) (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input logic req_write,
	input ddr5_burst_pkg::addr_t req_addr,
	input ddr5_burst_pkg::data_t req_data,
	input ddr5_burst_pkg::tag_t req_tag,
	output logic req_ready,
	input logic cmd_issue,
	input logic [$clog2(num_slots)-1:0] cmd_issue_slot,
	input logic beat_done,
	input logic [$clog2(num_slots)-1:0] beat_slot,
	input ddr5_burst_pkg::beat_t beat_idx,
	input ddr5_burst_pkg::data_t rd_beat_data,
	input logic ret_done,
	input logic [$clog2(num_slots)-1:0] ret_slot,
	input ddr5_burst_pkg::beat_t ret_beat,
	input logic ret_slot_free,
	output ddr5_burst_pkg::slot_state_e [num_slots-1:0] slot_state,
	output ddr5_burst_pkg::burst_key_t [num_slots-1:0] slot_key,
	output logic [num_slots-1:0] slot_write,
	output ddr5_burst_pkg::beat_mask_t [num_slots-1:0] slot_mask,
	output ddr5_burst_pkg::data_t [num_slots-1:0][ddr5_burst_pkg::burst_len-1:0] slot_data,
	output ddr5_burst_pkg::tag_t [num_slots-1:0][ddr5_burst_pkg::burst_len-1:0] slot_tag
);
	import ddr5_burst_pkg::*;

	localparam int slot_w = $clog2(num_slots);

	logic [slot_w-1:0] open_slot;   // burst currently being filled
	logic [slot_w-1:0] free_slot;
	logic [slot_w-1:0] tgt_slot;
	logic have_free;
	logic can_join;
	logic accept;
	burst_key_t req_key;
	beat_t req_beat;

	assign req_key = req_addr[29:4];
	assign req_beat = req_addr[3:0];

	// same block, same kind, beat not taken yet
	assign can_join = slot_state[open_slot] == slot_filling
		&& slot_key[open_slot] == req_key
		&& slot_write[open_slot] == req_write
		&& !slot_mask[open_slot][req_beat];

	assign req_ready = can_join || have_free;
	assign accept = req_valid && req_ready;
	assign tgt_slot = can_join ? open_slot : free_slot;

	// lowest empty slot
	always_comb begin
		free_slot = '0;
		have_free = 1'b0;
		for (int i = num_slots - 1; i >= 0; i--) begin
			if (slot_state[i] == slot_empty) begin
				free_slot = slot_w'(i);
				have_free = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_slots; i++) begin
				slot_state[i] <= slot_empty;
			end
			slot_mask <= '0;
			open_slot <= '0;
		end else begin
			// close the open burst unless this cycle adds to it
			if (slot_state[open_slot] == slot_filling && !(accept && can_join))
				slot_state[open_slot] <= slot_full;
			if (accept) begin
				if (can_join) begin
					slot_mask[open_slot][req_beat] <= 1'b1;
				end else begin
					slot_state[free_slot] <= slot_filling;
					slot_mask[free_slot] <= beat_mask_t'(1) << req_beat;
					open_slot <= free_slot;
				end
			end
			if (cmd_issue && slot_state[cmd_issue_slot] == slot_full)
				slot_state[cmd_issue_slot] <= slot_issued;
			if (beat_done && beat_idx == '0)
				slot_state[beat_slot] <= slot_returning;
			if (ret_done)
				slot_mask[ret_slot][ret_beat] <= 1'b0;   // request handed back
			if (ret_slot_free)
				slot_state[ret_slot] <= slot_empty;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			slot_tag[tgt_slot][req_beat] <= req_tag;
			if (req_write)
				slot_data[tgt_slot][req_beat] <= req_data;
			if (!can_join) begin
				slot_key[free_slot] <= req_key;
				slot_write[free_slot] <= req_write;
			end
		end
		// read beats land in place
		if (beat_done && !slot_write[beat_slot] && slot_mask[beat_slot][beat_idx])
			slot_data[beat_slot][beat_idx] <= rd_beat_data;
	end

	// a new burst only ever takes a slot that was empty
	a_new_slot_empty: assert property (@(posedge clk) disable iff (!rst_n)
		accept && !can_join |-> slot_state[free_slot] == slot_empty)
		else $error("request accepted without an empty slot");

endmodule

`default_nettype wire

// ==== logic/ddr5_cmd_encoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module ddr5_cmd_encoder #(
	parameter int num_slots = 4
) (
	input logic clk,
	input logic rst_n,
	input ddr5_burst_pkg::mem_cmd_e cmd,
	input logic [$clog2(num_slots)-1:0] cmd_slot,
	input ddr5_burst_pkg::burst_key_t [num_slots-1:0] slot_key,
	input ddr5_burst_pkg::beat_mask_t [num_slots-1:0] slot_mask,
	output logic cs_n,
	output ddr5_burst_pkg::ca_t ca,
	output logic cmd_issue,
	output logic [$clog2(num_slots)-1:0] cmd_issue_slot,
	output logic cmd_issue_write,
	output logic cmd_issue_read
);
	import ddr5_burst_pkg::*;

	localparam logic bl_bit = 1'b1;   // BL16
	localparam logic ap_bit = 1'b0;   // auto-precharge

	typedef enum logic [1:0] {ph_idle, ph_one, ph_two} phase_e;

	phase_e phase;
	mem_cmd_e lat_cmd;
	burst_key_t lat_key;
	logic lat_full;
	logic [1:0] bg;
	logic [1:0] bank;
	logic [15:0] row;
	logic [5:0] col_blk;
	ca_t ca_p1;
	ca_t ca_p2;

	assign bg = lat_key[25:24];
	assign bank = lat_key[23:22];
	assign row = lat_key[21:6];
	assign col_blk = lat_key[5:0];

	assign cmd_issue_read = cmd == cmd_read;
	assign cmd_issue_write = cmd == cmd_write;
	assign cmd_issue = cmd_issue_read || cmd_issue_write;
	assign cmd_issue_slot = cmd_slot;

	always_comb begin
		ca_p1 = '0;
		ca_p2 = '0;
		case (lat_cmd)
			cmd_activate: begin
				ca_p1 = {4'b0, bg, bank, row[3:0], 2'b00};
				ca_p2 = {2'b0, row[15:4]};
			end
			cmd_read: begin
				ca_p1 = {4'b0, bg, bank, bl_bit, op_read};
				ca_p2 = {4'b0, ap_bit, 1'b0, col_blk, 2'b00};
			end
			cmd_write: begin
				ca_p1 = {4'b0, bg, bank, bl_bit, op_write};
				ca_p2 = {3'b0, lat_full, ap_bit, 1'b0, col_blk, 2'b00};
			end
			cmd_precharge: ca_p1 = {4'b0, bg, bank, op_precharge};
			cmd_refresh_all: ca_p1 = {9'b0, op_refresh_all};
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= ph_idle;
			lat_cmd <= cmd_none;
			cs_n <= 1'b1;
			ca <= '0;
		end else begin
			case (phase)
				ph_one: begin
					cs_n <= 1'b0;
					ca <= ca_p1;
					phase <= ph_two;
				end
				ph_two: begin
					cs_n <= 1'b1;
					ca <= ca_p2;
					phase <= ph_idle;
				end
				default: begin
					cs_n <= 1'b1;
					ca <= '0;
				end
			endcase
			if (cmd != cmd_none) begin
				lat_cmd <= cmd;
				phase <= ph_one;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd != cmd_none) begin
			lat_key <= slot_key[cmd_slot];
			lat_full <= &slot_mask[cmd_slot];
		end
	end

	// phase 2 would be overwritten by a back-to-back command
	a_cmd_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		cmd != cmd_none |=> cmd == cmd_none)
		else $error("commands closer than two cycles");

endmodule

`default_nettype wire

// ==== logic/burst_data_mover.sv ====
`timescale 1ns/100ps
`default_nettype none

module burst_data_mover #(
	parameter int num_slots = 4,
	parameter int read_latency = 22,
	parameter int write_latency = 21
) (
	input logic clk,
	input logic rst_n,
	input logic cmd_issue_read,
	input logic cmd_issue_write,
	input logic [$clog2(num_slots)-1:0] cmd_issue_slot,
	input ddr5_burst_pkg::beat_mask_t [num_slots-1:0] slot_mask,
	input ddr5_burst_pkg::data_t [num_slots-1:0][ddr5_burst_pkg::burst_len-1:0] slot_data,
	input ddr5_burst_pkg::data_t dq_in,
	output ddr5_burst_pkg::data_t dq_out,
	output logic dq_oe,
	output logic dm_n,
	output logic beat_done,
	output logic [$clog2(num_slots)-1:0] beat_slot,
	output ddr5_burst_pkg::beat_t beat_idx,
	output ddr5_burst_pkg::data_t rd_beat_data,
	output logic [num_slots-1:0][$clog2(ddr5_burst_pkg::burst_len+1)-1:0] beats_moved
);
	import ddr5_burst_pkg::*;

	localparam int max_lat = (read_latency > write_latency) ? read_latency : write_latency;
	localparam int cnt_w = $clog2(max_lat + burst_len + 2);
	localparam int moved_w = $clog2(burst_len + 1);

	logic active;
	logic cur_write;
	logic [$clog2(num_slots)-1:0] cur_slot;
	logic [cnt_w-1:0] cnt;        // 0 in the cycle before phase 1
	logic [cnt_w-1:0] start;      // cnt value of beat 0
	logic in_window;
	logic beat_marked;

	assign start = cur_write ? cnt_w'(write_latency + 1) : cnt_w'(read_latency + 1);
	assign in_window = active && cnt >= start;
	assign beat_idx = beat_t'(cnt - start);
	assign beat_slot = cur_slot;
	assign beat_done = in_window;
	assign beat_marked = slot_mask[cur_slot][beat_idx];

	// write beats
	assign dq_oe = in_window && cur_write;
	assign dm_n = !(dq_oe && beat_marked);
	assign dq_out = (dq_oe && beat_marked) ? slot_data[cur_slot][beat_idx] : '0;

	assign rd_beat_data = dq_in;   // stored by the collector when marked

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			cur_write <= 1'b0;
			cur_slot <= '0;
			cnt <= '0;
			beats_moved <= '0;
		end else begin
			if (in_window)
				beats_moved[cur_slot] <= moved_w'(beat_idx) + moved_w'(1);
			if (cmd_issue_read || cmd_issue_write) begin
				active <= 1'b1;
				cur_write <= cmd_issue_write;
				cur_slot <= cmd_issue_slot;
				cnt <= '0;
				beats_moved[cmd_issue_slot] <= '0;
			end else if (active) begin
				if (cnt == start + cnt_w'(burst_len - 1))
					active <= 1'b0;   // last beat
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/burst_returner.sv ====
`timescale 1ns/100ps
`default_nettype none

module burst_returner #(
	parameter int num_slots = 4
) (
	input logic clk,
	input logic rst_n,
	input ddr5_burst_pkg::slot_state_e [num_slots-1:0] slot_state,
	input ddr5_burst_pkg::beat_mask_t [num_slots-1:0] slot_mask,
	input logic [num_slots-1:0] slot_write,
	input ddr5_burst_pkg::data_t [num_slots-1:0][ddr5_burst_pkg::burst_len-1:0] slot_data,
	input ddr5_burst_pkg::tag_t [num_slots-1:0][ddr5_burst_pkg::burst_len-1:0] slot_tag,
	input logic [num_slots-1:0][$clog2(ddr5_burst_pkg::burst_len+1)-1:0] beats_moved,
	output logic ret_valid,
	output logic ret_write,
	output ddr5_burst_pkg::tag_t ret_tag,
	output ddr5_burst_pkg::data_t ret_data,
	output logic ret_done,
	output logic [$clog2(num_slots)-1:0] ret_slot,
	output ddr5_burst_pkg::beat_t ret_beat,
	output logic ret_slot_free
);
	import ddr5_burst_pkg::*;

	localparam int slot_w = $clog2(num_slots);
	localparam int moved_w = $clog2(burst_len + 1);

	logic locked;
	logic [slot_w-1:0] lock_slot;
	logic have;
	logic returning;

	// stay on the locked slot, otherwise take the lowest returning one
	always_comb begin
		ret_slot = lock_slot;
		have = locked;
		if (!locked) begin
			for (int i = num_slots - 1; i >= 0; i--) begin
				if (slot_state[i] == slot_returning) begin
					ret_slot = slot_w'(i);
					have = 1'b1;
				end
			end
		end
		ret_beat = '0;
		for (int i = burst_len - 1; i >= 0; i--) begin
			if (slot_mask[ret_slot][i])
				ret_beat = beat_t'(i);
		end
	end

	assign returning = have && slot_state[ret_slot] == slot_returning;
	assign ret_done = returning && slot_mask[ret_slot] != '0
		&& beats_moved[ret_slot] > moved_w'(ret_beat);   // beat already on the bus
	assign ret_slot_free = returning && slot_mask[ret_slot] == '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			locked <= 1'b0;
			lock_slot <= '0;
			ret_valid <= 1'b0;
		end else begin
			ret_valid <= ret_done;
			if (ret_slot_free) begin
				locked <= 1'b0;
			end else if (returning) begin
				locked <= 1'b1;
				lock_slot <= ret_slot;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ret_done) begin
			ret_write <= slot_write[ret_slot];
			ret_tag <= slot_tag[ret_slot][ret_beat];
			ret_data <= slot_data[ret_slot][ret_beat];
		end
	end

	// collector must clear the mask bit before the next pick
	a_no_repeat: assert property (@(posedge clk) disable iff (!rst_n)
		ret_done |=> !(ret_done && ret_slot == $past(ret_slot) && ret_beat == $past(ret_beat)))
		else $error("beat returned twice");

endmodule

`default_nettype wire

// ==== logic/burst_handler.sv ====
`timescale 1ns/100ps
`default_nettype none

module burst_handler #(
	parameter int num_slots = 4,
	parameter int read_latency = 22,
	parameter int write_latency = 21
) (
	input logic clk,
	input logic rst_n,
	// bank arbiter
	input logic req_valid,
	input logic req_write,
	input ddr5_burst_pkg::addr_t req_addr,
	input ddr5_burst_pkg::data_t req_data,
	input ddr5_burst_pkg::tag_t req_tag,
	output logic req_ready,
	// timing controller
	output ddr5_burst_pkg::slot_state_e [num_slots-1:0] slot_state,
	output ddr5_burst_pkg::burst_key_t [num_slots-1:0] slot_key,
	output logic [num_slots-1:0] slot_write,
	input ddr5_burst_pkg::mem_cmd_e cmd,
	input logic [$clog2(num_slots)-1:0] cmd_slot,
	// memory
	output logic cs_n,
	output ddr5_burst_pkg::ca_t ca,
	output ddr5_burst_pkg::data_t dq_out,
	output logic dq_oe,
	input ddr5_burst_pkg::data_t dq_in,
	output logic dm_n,
	// returner
	output logic ret_valid,
	output logic ret_write,
	output ddr5_burst_pkg::tag_t ret_tag,
	output ddr5_burst_pkg::data_t ret_data
);
	import ddr5_burst_pkg::*;

	beat_mask_t [num_slots-1:0] slot_mask;
	data_t [num_slots-1:0][burst_len-1:0] slot_data;
	tag_t [num_slots-1:0][burst_len-1:0] slot_tag;
	logic cmd_issue;
	logic cmd_issue_read;
	logic cmd_issue_write;
	logic [$clog2(num_slots)-1:0] cmd_issue_slot;
	logic beat_done;
	logic [$clog2(num_slots)-1:0] beat_slot;
	beat_t beat_idx;
	data_t rd_beat_data;
	logic [num_slots-1:0][$clog2(burst_len+1)-1:0] beats_moved;
	logic ret_done;
	logic [$clog2(num_slots)-1:0] ret_slot;
	beat_t ret_beat;
	logic ret_slot_free;

	// port names match the nets above one to one
	burst_collector #(.num_slots(num_slots)) burst_collector_inst (.*);

	ddr5_cmd_encoder #(.num_slots(num_slots)) ddr5_cmd_encoder_inst (.*);

	burst_data_mover #(
		.num_slots(num_slots),
		.read_latency(read_latency),
		.write_latency(write_latency)
	) burst_data_mover_inst (.*);

	burst_returner #(.num_slots(num_slots)) burst_returner_inst (.*);

endmodule

`default_nettype wire

// ==== tests/tb_burst_handler.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_burst_handler;
	import ddr5_burst_pkg::*;

	localparam int num_slots = 4;
	localparam int read_latency = 22;
	localparam int write_latency = 21;

	typedef enum logic [1:0] {st_req, st_cmd, st_idle, st_state} step_kind_e;

	typedef struct packed {
		step_kind_e kind;
		logic wr;
		addr_t addr;
		tag_t tag;
		logic [1:0] slot;
		logic rdy;
		mem_cmd_e cmd;
		int n;
		slot_state_e st;
	} step_t;

	logic clk;
	logic rst_n;
	logic req_valid;
	logic req_write;
	addr_t req_addr;
	data_t req_data;
	tag_t req_tag;
	logic req_ready;
	slot_state_e [num_slots-1:0] slot_state;
	burst_key_t [num_slots-1:0] slot_key;
	logic [num_slots-1:0] slot_write;
	mem_cmd_e cmd;
	logic [1:0] cmd_slot;
	logic cs_n;
	ca_t ca;
	data_t dq_out;
	logic dq_oe;
	data_t dq_in;
	logic dm_n;
	logic ret_valid;
	logic ret_write;
	tag_t ret_tag;
	data_t ret_data;

	// model of what each slot should hold
	beat_mask_t m_mask [num_slots];
	burst_key_t m_key [num_slots];
	logic m_wr [num_slots];
	data_t m_data [num_slots][burst_len];
	tag_t m_tag [num_slots][burst_len];

	logic exp_wr_q [$];
	tag_t exp_tag_q [$];
	data_t exp_data_q [$];
	step_t steps [$];
	int limit;
	logic table_ready = 1'b0;

	burst_handler burst_handler_inst (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (exp !== act)
			abort_run($sformatf("ERROR %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_ca(string name, ca_t exp, ca_t act);
		if (exp !== act)
			abort_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_data(string name, data_t exp, data_t act);
		if (exp !== act)
			abort_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_tag(string name, tag_t exp, tag_t act);
		if (exp !== act)
			abort_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_key(string name, burst_key_t exp, burst_key_t act);
		if (exp !== act)
			abort_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_state(string name, slot_state_e exp, slot_state_e act);
		if (exp !== act)
			abort_run($sformatf("ERROR %s expected %s actual %s", name, exp.name(), act.name()));
	endtask

	function automatic addr_t mk_addr(logic [1:0] bg, logic [1:0] bank, logic [15:0] row,
			logic [9:0] col);
		return {bg, bank, row, col};
	endfunction

	// memory contents seen on read beats
	function automatic data_t mem_value(burst_key_t key, beat_t k);
		return key[15:0] ^ {k, ~k, k, ~k};
	endfunction

	function automatic ca_t ca_expect(mem_cmd_e c, burst_key_t key, logic full, bit second);
		logic [1:0] bg;
		logic [1:0] bank;
		logic [15:0] row;
		logic [5:0] col;
		ca_t p1;
		ca_t p2;
		bg = key[25:24];
		bank = key[23:22];
		row = key[21:6];
		col = key[5:0];
		p1 = '0;
		p2 = '0;
		case (c)
			cmd_activate: begin
				p1 = ca_t'({bg, bank, row[3:0], 2'b00});
				p2 = ca_t'(row[15:4]);
			end
			cmd_read: begin
				p1 = ca_t'({bg, bank, 1'b1, op_read});
				p2 = ca_t'({2'b00, col, 2'b00});   // ap = 0
			end
			cmd_write: begin
				p1 = ca_t'({bg, bank, 1'b1, op_write});
				p2 = ca_t'({full, 2'b00, col, 2'b00});
			end
			cmd_precharge: p1 = ca_t'({bg, bank, op_precharge});
			cmd_refresh_all: p1 = ca_t'(op_refresh_all);
			default: ;
		endcase
		return second ? p2 : p1;
	endfunction

	task automatic add_req(logic wr, addr_t addr, tag_t tag, logic [1:0] slot, logic rdy);
		step_t s;
		s = '0;
		s.kind = st_req;
		s.wr = wr;
		s.addr = addr;
		s.tag = tag;
		s.slot = slot;
		s.rdy = rdy;
		steps.push_back(s);
	endtask

	task automatic add_step(step_kind_e kind, mem_cmd_e c, logic [1:0] slot, int n,
			slot_state_e st);
		step_t s;
		s = '0;
		s.kind = kind;
		s.cmd = c;
		s.slot = slot;
		s.n = n;
		s.st = st;
		steps.push_back(s);
	endtask

	task automatic issue_command(string name, mem_cmd_e c, logic [1:0] sl);
		int lat;
		logic full;
		logic burst;
		burst_key_t key;
		key = m_key[sl];
		full = &m_mask[sl];
		burst = c == cmd_read || c == cmd_write;
		lat = (c == cmd_read) ? read_latency : write_latency;
		cmd <= c;
		cmd_slot <= sl;
		if (burst) begin
			for (int k = 0; k < burst_len; k++) begin
				if (m_mask[sl][k]) begin   // returns come back in beat order
					exp_wr_q.push_back(c == cmd_write);
					exp_tag_q.push_back(m_tag[sl][k]);
					exp_data_q.push_back(c == cmd_write ? m_data[sl][k] : mem_value(key, beat_t'(k)));
				end
			end
		end
		@(posedge clk);
		cmd <= cmd_none;
		@(posedge clk);
		@(negedge clk);
		check_bit({name, " cs_n phase 1"}, 1'b0, cs_n);
		check_ca({name, " ca phase 1"}, ca_expect(c, key, full, 0), ca);
		@(negedge clk);
		check_bit({name, " cs_n phase 2"}, 1'b1, cs_n);
		check_ca({name, " ca phase 2"}, ca_expect(c, key, full, 1), ca);
		@(negedge clk);
		check_ca({name, " ca idle"}, '0, ca);
		if (burst) begin
			repeat (lat - 3) @(posedge clk);
			@(negedge clk);
			check_bit({name, " dq_oe before beat 0"}, 1'b0, dq_oe);
			@(posedge clk);
			for (int k = 0; k < burst_len; k++) begin
				if (c == cmd_read)
					dq_in <= mem_value(key, beat_t'(k));
				@(negedge clk);
				if (c == cmd_write) begin
					check_bit($sformatf("%s dq_oe beat %0d", name, k), 1'b1, dq_oe);
					check_bit($sformatf("%s dm_n beat %0d", name, k), !m_mask[sl][k], dm_n);
					if (m_mask[sl][k])
						check_data($sformatf("%s dq_out beat %0d", name, k), m_data[sl][k], dq_out);
				end
				@(posedge clk);
			end
			dq_in <= '0;
			m_mask[sl] = '0;
		end
	endtask

	// every return must match the head of the expected queue
	always @(negedge clk) begin
		if (rst_n && ret_valid) begin
			if (exp_tag_q.size() == 0)
				abort_run("a request was returned that was never issued");
			check_bit("ret_write", exp_wr_q.pop_front(), ret_write);
			check_tag("ret_tag", exp_tag_q.pop_front(), ret_tag);
			check_data("ret_data", exp_data_q.pop_front(), ret_data);
		end
	end

	initial begin
		wait (table_ready);
		repeat (limit) @(posedge clk);
		abort_run("timeout: the run did not finish in time");
	end

	initial begin
		step_t s;
		data_t d;
		string name;
		void'($urandom(32'h2498f235));
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_data = '0;
		req_tag = '0;
		cmd = cmd_none;
		cmd_slot = '0;
		dq_in = '0;
		for (int i = 0; i < num_slots; i++)
			m_mask[i] = '0;

		// three writes in one block, then splits by row and kind
		add_req(1, mk_addr(2'd1, 2'd2, 16'h1234, 10'h050), 4'd1, 2'd0, 1);
		add_req(1, mk_addr(2'd1, 2'd2, 16'h1234, 10'h053), 4'd2, 2'd0, 1);
		add_req(1, mk_addr(2'd1, 2'd2, 16'h1234, 10'h05f), 4'd3, 2'd0, 1);
		add_step(st_idle, cmd_none, 2'd0, 1, slot_empty);
		add_step(st_state, cmd_none, 2'd0, 0, slot_full);
		add_req(1, mk_addr(2'd1, 2'd2, 16'h1235, 10'h050), 4'd4, 2'd1, 1);
		add_req(0, mk_addr(2'd1, 2'd2, 16'h1234, 10'h052), 4'd5, 2'd2, 1);
		add_req(0, mk_addr(2'd1, 2'd2, 16'h1234, 10'h058), 4'd6, 2'd2, 1);
		add_req(0, mk_addr(2'd3, 2'd0, 16'h0777, 10'h3c1), 4'd7, 2'd3, 1);
		add_step(st_idle, cmd_none, 2'd0, 1, slot_empty);
		add_step(st_state, cmd_none, 2'd1, 0, slot_full);
		add_step(st_state, cmd_none, 2'd2, 0, slot_full);
		add_step(st_state, cmd_none, 2'd3, 0, slot_full);
		add_req(1, mk_addr(2'd0, 2'd1, 16'h0100, 10'h000), 4'd8, 2'd0, 0);   // all busy
		add_step(st_idle, cmd_none, 2'd0, 2, slot_empty);
		add_step(st_cmd, cmd_activate, 2'd0, 0, slot_empty);
		add_step(st_cmd, cmd_write, 2'd0, 0, slot_empty);
		add_step(st_cmd, cmd_write, 2'd1, 0, slot_empty);
		add_step(st_cmd, cmd_read, 2'd2, 0, slot_empty);
		add_step(st_cmd, cmd_precharge, 2'd2, 0, slot_empty);
		add_step(st_cmd, cmd_refresh_all, 2'd0, 0, slot_empty);
		add_step(st_idle, cmd_none, 2'd0, 4, slot_empty);
		for (int i = 0; i < 3; i++)
			add_step(st_state, cmd_none, 2'(i), 0, slot_empty);
		add_step(st_cmd, cmd_read, 2'd3, 0, slot_empty);
		add_step(st_idle, cmd_none, 2'd0, 4, slot_empty);
		add_step(st_state, cmd_none, 2'd3, 0, slot_empty);

		// every beat marked, so the write flag in phase 2 is set
		for (int b = 0; b < burst_len; b++)
			add_req(1, mk_addr(2'd2, 2'd1, 16'h00aa, 10'h120 + 10'(b)), tag_t'(b), 2'd0, 1);
		add_step(st_idle, cmd_none, 2'd0, 1, slot_empty);
		add_step(st_state, cmd_none, 2'd0, 0, slot_full);
		add_step(st_cmd, cmd_write, 2'd0, 0, slot_empty);
		add_step(st_idle, cmd_none, 2'd0, 4, slot_empty);
		add_step(st_state, cmd_none, 2'd0, 0, slot_empty);

		limit = 20;
		foreach (steps[i]) begin
			limit += (steps[i].kind == st_idle) ? steps[i].n : 1;
			if (steps[i].cmd == cmd_read || steps[i].cmd == cmd_write)
				limit += 60;
		end
		table_ready = 1'b1;

		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_bit("reset cs_n", 1'b1, cs_n);
		check_ca("reset ca", '0, ca);
		check_bit("reset dq_oe", 1'b0, dq_oe);
		check_bit("reset dm_n", 1'b1, dm_n);
		check_bit("reset ret_valid", 1'b0, ret_valid);
		check_bit("reset req_ready", 1'b1, req_ready);
		for (int i = 0; i < num_slots; i++)
			check_state($sformatf("reset slot %0d", i), slot_empty, slot_state[i]);

		foreach (steps[i]) begin
			s = steps[i];
			name = $sformatf("step %0d", i);
			@(posedge clk);
			if (s.kind != st_req)
				req_valid <= 1'b0;
			case (s.kind)
				st_req: begin
					d = data_t'($urandom);
					req_valid <= 1'b1;
					req_write <= s.wr;
					req_addr <= s.addr;
					req_data <= d;
					req_tag <= s.tag;
					@(negedge clk);
					check_bit({name, " req_ready"}, s.rdy, req_ready);
					if (s.rdy) begin   // taken on the next edge
						m_mask[s.slot][s.addr[3:0]] = 1'b1;
						m_key[s.slot] = s.addr[29:4];
						m_wr[s.slot] = s.wr;
						m_data[s.slot][s.addr[3:0]] = d;
						m_tag[s.slot][s.addr[3:0]] = s.tag;
					end
				end
				st_cmd: issue_command(name, s.cmd, s.slot);
				st_idle: repeat (s.n - 1) @(posedge clk);
				default: begin
					@(negedge clk);
					check_state({name, " slot_state"}, s.st, slot_state[s.slot]);
					if (s.st != slot_empty) begin   // key and kind of a live slot
						check_key({name, " slot_key"}, m_key[s.slot], slot_key[s.slot]);
						check_bit({name, " slot_write"}, m_wr[s.slot], slot_write[s.slot]);
					end
				end
			endcase
		end

		wait (exp_tag_q.size() == 0);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/ddr5_burst_pkg.sv
logic/burst_collector.sv
logic/ddr5_cmd_encoder.sv
logic/burst_data_mover.sv
logic/burst_returner.sv
logic/burst_handler.sv
tests/tb_burst_handler.sv

// ==== run.sh ====
#!/bin/sh
# build and run the burst handler testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f \
	--top-module tb_burst_handler -o sim_burst_handler
./obj_dir/sim_burst_handler
